// File: src/int_div_consts.svh
/*
  sizing constants for the iterative divide unit
  include wherever the operand width or the iteration count is needed
*/

`ifndef INT_DIV_CONSTS_SVH
`define INT_DIV_CONSTS_SVH

// --------------------
// operand sizing
// --------------------

// width of one operand word
`define DIV_XLEN 32

// one quotient bit per iteration
`define DIV_ITERS `DIV_XLEN

`endif

// File: src/int_div_pkg.sv
/*
  types shared by the divide unit stages
  import into a module header to get the request, operand and result structs
*/

`include "int_div_consts.svh"

`default_nettype none

package int_div_pkg;

  // --------------------
  // function select
  // --------------------

  // signed divide is encoding 0
  typedef enum logic {
    DIV_SIGNED   = 1'b0,
    DIV_UNSIGNED = 1'b1
  } div_fn_e;

  // --------------------
  // payloads
  // --------------------

  // request from outside, 65 bits
  typedef struct packed {
    div_fn_e              fn;
    logic [`DIV_XLEN-1:0] a;
    logic [`DIV_XLEN-1:0] b;
  } div_req_t;

  // prepared operands headed into the core, 66 bits
  typedef struct packed {
    logic [`DIV_XLEN-1:0] mag_a;
    logic [`DIV_XLEN-1:0] mag_b;
    logic                 quo_neg;
    logic                 rem_neg;
  } div_operands_t;

  // response word, remainder above quotient
  typedef struct packed {
    logic [`DIV_XLEN-1:0] rem;
    logic [`DIV_XLEN-1:0] quo;
  } div_result_t;

  // unsigned core result with the sign flags riding along
  typedef struct packed {
    div_result_t result;
    logic        quo_neg;
    logic        rem_neg;
  } div_core_out_t;

endpackage

`default_nettype wire

// File: src/int_div_operand_prep.sv
/*
  front stage of the divide unit
  turns a signed or unsigned request into magnitudes plus sign flags, one entry deep
*/

`include "int_div_consts.svh"

`default_nettype none

module int_div_operand_prep
  import int_div_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  input  div_req_t      req,
  input  logic          req_val,
  output logic          req_rdy,

  output div_operands_t ops,
  output logic          ops_val,
  input  logic          ops_rdy
);

  // --------------------
  // sign handling
  // --------------------

  logic                 is_signed;
  logic                 a_neg;
  logic                 b_neg;
  logic [`DIV_XLEN-1:0] mag_a;
  logic [`DIV_XLEN-1:0] mag_b;
  div_operands_t        ops_next;

  assign is_signed = (req.fn == DIV_SIGNED);

  // top bit only counts as a sign for signed divides
  assign a_neg = is_signed && req.a[`DIV_XLEN-1];
  assign b_neg = is_signed && req.b[`DIV_XLEN-1];

  // two's complement magnitude
  assign mag_a = a_neg ? (~req.a + 1'b1) : req.a;
  assign mag_b = b_neg ? (~req.b + 1'b1) : req.b;

  // quotient flips when exactly one operand is negative
  // remainder follows the dividend
  always_comb begin
    ops_next.mag_a   = mag_a;
    ops_next.mag_b   = mag_b;
    ops_next.quo_neg = a_neg ^ b_neg;
    ops_next.rem_neg = a_neg;
  end

  // --------------------
  // output register
  // --------------------

  // room when empty or when the entry leaves this edge
  assign req_rdy = !ops_val || ops_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      ops_val <= 1'b0;
    end else if (req_rdy) begin
      ops_val <= req_val;
    end
  end

  // payload only moves on an accepted request
  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      ops <= ops_next;
    end
  end

endmodule

`default_nettype wire

// File: src/int_div_iterative.sv
/*
  restoring shift-subtract divider core, one quotient bit per cycle
  takes magnitudes from the prep stage and hands an unsigned result to the fix stage
*/

`include "int_div_consts.svh"

`default_nettype none

module int_div_iterative
  import int_div_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  input  div_operands_t ops,
  input  logic          ops_val,
  output logic          ops_rdy,

  output div_core_out_t res,
  output logic          res_val,
  input  logic          res_rdy
);

  localparam int XLEN  = `DIV_XLEN;
  localparam int CNT_W = $clog2(`DIV_ITERS);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`DIV_ITERS - 1);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_CALC = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  // --------------------
  // control
  // --------------------

  logic [1:0]       state;
  logic [CNT_W-1:0] count;
  logic             load;
  logic             step;
  logic             take;

  assign ops_rdy = (state == ST_IDLE);
  assign res_val = (state == ST_DONE);

  assign load = ops_val && ops_rdy;
  assign step = (state == ST_CALC);
  assign take = res_val && res_rdy;

  // count runs down from DIV_ITERS-1, last step when it hits zero
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (load) begin
            state <= ST_CALC;
            count <= CNT_LOAD;
          end
        end
        ST_CALC: begin
          if (count == '0) begin
            state <= ST_DONE;
          end else begin
            count <= count - 1'b1;
          end
        end
        ST_DONE: begin
          // result taken, free for the next divide
          if (take) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------

  // rq holds a spare top bit, the partial remainder, then the quotient
  logic [2*XLEN:0] rq;
  logic [2*XLEN:0] divisor;
  logic            quo_neg;
  logic            rem_neg;
  logic [2*XLEN:0] rq_shift;
  logic [2*XLEN:0] rq_diff;
  logic [2*XLEN:0] rq_next;

  assign rq_shift = rq << 1;
  assign rq_diff  = rq_shift - divisor;

  // negative difference means restore and shift in a zero
  assign rq_next = rq_diff[2*XLEN] ? {rq_shift[2*XLEN:1], 1'b0}
                                   : {rq_diff[2*XLEN:1], 1'b1};

  always_ff @(posedge clk) begin
    if (load) begin
      rq      <= {{(XLEN+1){1'b0}}, ops.mag_a};
      // divisor lines up with the remainder half
      divisor <= {1'b0, ops.mag_b, {XLEN{1'b0}}};
      quo_neg <= ops.quo_neg;
      rem_neg <= ops.rem_neg;
    end else if (step) begin
      rq      <= rq_next;
    end
  end

  // remainder fits in XLEN bits once all steps are done
  always_comb begin
    res.result.rem = rq[2*XLEN-1:XLEN];
    res.result.quo = rq[XLEN-1:0];
    res.quo_neg    = quo_neg;
    res.rem_neg    = rem_neg;
  end

endmodule

`default_nettype wire

// File: src/int_div_result_fix.sv
/*
  back stage of the divide unit
  restores the signs of quotient and remainder and holds the response for the consumer
*/

`default_nettype none

module int_div_result_fix
  import int_div_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  input  div_core_out_t core,
  input  logic          core_val,
  output logic          core_rdy,

  output div_result_t   resp,
  output logic          resp_val,
  input  logic          resp_rdy
);

  // --------------------
  // sign restore
  // --------------------

  div_result_t resp_next;

  // negate by two's complement when flagged
  always_comb begin
    resp_next.quo = core.quo_neg ? (~core.result.quo + 1'b1) : core.result.quo;
    resp_next.rem = core.rem_neg ? (~core.result.rem + 1'b1) : core.result.rem;
  end

  // --------------------
  // response register
  // --------------------

  // same one-entry rule as the prep stage
  assign core_rdy = !resp_val || resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (core_rdy) begin
      resp_val <= core_val;
    end
  end

  // held steady while the consumer stalls
  always_ff @(posedge clk) begin
    if (core_val && core_rdy) begin
      resp <= resp_next;
    end
  end

endmodule

`default_nettype wire

// File: src/int_div_unit.sv
/*
  top of the 32-bit iterative divide unit
  request in as fn, a, b and response out as remainder above quotient, both valid/ready
*/

`default_nettype none

module int_div_unit
  import int_div_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  input  div_req_t    req,
  input  logic        req_val,
  output logic        req_rdy,

  output div_result_t resp,
  output logic        resp_val,
  input  logic        resp_rdy
);

  // --------------------
  // stage links
  // --------------------

  // prep to core
  div_operands_t ops;
  logic          prep_val;
  logic          core_rdy;

  // core to fix
  div_core_out_t core_out;
  logic          core_val;
  logic          fix_rdy;

  // magnitudes and sign flags
  int_div_operand_prep i_prep (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .ops     (ops),
    .ops_val (prep_val),
    .ops_rdy (core_rdy)
  );

  // 32 shift-subtract steps per divide
  int_div_iterative i_core (
    .clk     (clk),
    .reset   (reset),
    .ops     (ops),
    .ops_val (prep_val),
    .ops_rdy (core_rdy),
    .res     (core_out),
    .res_val (core_val),
    .res_rdy (fix_rdy)
  );

  // signed result and response hold
  int_div_result_fix i_fix (
    .clk      (clk),
    .reset    (reset),
    .core     (core_out),
    .core_val (core_val),
    .core_rdy (fix_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

endmodule

`default_nettype wire

// File: verification/int_div_unit_chk.sv
/*
  concurrent assertions on the divide unit handshakes and the core busy window
  bound into int_div_unit, fail_count lets the testbench see a firing
*/

`include "int_div_consts.svh"

`default_nettype none

module int_div_unit_chk
  import int_div_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  div_req_t    req,
  input  logic        req_val,
  input  logic        req_rdy,
  input  div_result_t resp,
  input  logic        resp_val,
  input  logic        resp_rdy,
  input  logic        core_ops_val,
  input  logic        core_ops_rdy
);

  int fail_count = 0;

  // --------------------
  // handshakes
  // --------------------

  // stalled request keeps val and payload
  req_hold: assert property (@(posedge clk) disable iff (reset)
      req_val && !req_rdy |=> req_val && $stable(req))
    else begin
      fail_count++;
      $error("request changed while req_rdy was low");
    end

  // stalled response keeps val and payload
  resp_hold: assert property (@(posedge clk) disable iff (reset)
      resp_val && !resp_rdy |=> resp_val && $stable(resp))
    else begin
      fail_count++;
      $error("response changed while resp_rdy was low");
    end

  // --------------------
  // core and reset
  // --------------------

  // core takes nothing new during its iterations
  core_busy: assert property (@(posedge clk) disable iff (reset)
      core_ops_val && core_ops_rdy |=> !core_ops_rdy [*`DIV_ITERS])
    else begin
      fail_count++;
      $error("core was ready while computing");
    end

  // falling edge, the flop only holds its reset value after the first rising edge
  reset_quiet: assert property (@(negedge clk) reset |-> !resp_val)
    else begin
      fail_count++;
      $error("resp_val high during reset");
    end

endmodule

bind int_div_unit int_div_unit_chk i_chk (
  .clk          (clk),
  .reset        (reset),
  .req          (req),
  .req_val      (req_val),
  .req_rdy      (req_rdy),
  .resp         (resp),
  .resp_val     (resp_val),
  .resp_rdy     (resp_rdy),
  .core_ops_val (i_core.ops_val),
  .core_ops_rdy (i_core.ops_rdy)
);

`default_nettype wire

// File: verification/int_div_unit_tb.sv
/*
  testbench for the divide unit, stimulus and expected values from int_div_tests.txt
  runs all tests back to back under random back-pressure, then times one lone request
*/

`include "int_div_consts.svh"

`default_nettype none

module int_div_unit_tb
  import int_div_pkg::*;
();

  logic        clk;
  logic        reset;
  div_req_t    req;
  logic        req_val;
  logic        req_rdy;
  div_result_t resp;
  logic        resp_val;
  logic        resp_rdy;

  // tests as read from the file
  div_req_t    test_req[$];
  div_result_t test_exp[$];
  // outstanding requests in order
  div_result_t exp_q[$];
  int          rx_count;
  bit          tests_loaded;
  bit          hold_rdy;

  int_div_unit i_int_div_unit (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // --------------------
  // helpers
  // --------------------

  task automatic fail_run(string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_result(div_result_t got, div_result_t exp_res);
    if (got.quo !== exp_res.quo) begin
      fail_run($sformatf("mismatch at %0t: resp.quo got %h expected %h",
                         $time, got.quo, exp_res.quo));
    end
    if (got.rem !== exp_res.rem) begin
      fail_run($sformatf("mismatch at %0t: resp.rem got %h expected %h",
                         $time, got.rem, exp_res.rem));
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [31:0] fn_v;
    logic [31:0] a_v;
    logic [31:0] b_v;
    logic [31:0] rem_v;
    logic [31:0] quo_v;
    div_req_t    r;
    div_result_t e;
    fd = $fopen("verification/int_div_tests.txt", "r");
    if (fd == 0) begin
      fail_run("could not open verification/int_div_tests.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // comment and blank lines
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h", fn_v, a_v, b_v, rem_v, quo_v);
      if (n != 5) begin
        fail_run($sformatf("malformed line in the tests file: %s", line));
      end
      r.fn  = div_fn_e'(fn_v[0]);
      r.a   = a_v;
      r.b   = b_v;
      e.rem = rem_v;
      e.quo = quo_v;
      test_req.push_back(r);
      test_exp.push_back(e);
    end
    $fclose(fd);
    if (test_req.size() == 0) begin
      fail_run("the tests file holds no tests");
    end
  endtask

  // called just after a rising edge, returns on the edge of the transfer
  task automatic send_request(int idx);
    req     <= test_req[idx];
    req_val <= 1'b1;
    do begin
      @(posedge clk);
    end while (!req_rdy);
    exp_q.push_back(test_exp[idx]);
  endtask

  // prep, core load, then one edge per iteration
  task automatic check_latency(int idx);
    int edges;
    send_request(idx);
    req_val <= 1'b0;
    edges = 0;
    // resp_val sampled between edges
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!resp_val && edges < 100);
    if (!resp_val) begin
      fail_run("resp_val never rose for the timed request");
    end
    if (edges != `DIV_ITERS + 2) begin
      fail_run($sformatf("mismatch at %0t: resp_val latency got %0d expected %0d",
                         $time, edges, `DIV_ITERS + 2));
    end
  endtask

  // --------------------
  // clock, back-pressure, watchdog
  // --------------------

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // low about a third of the time
  initial begin
    void'($urandom(32'he1e65daa));
    forever begin
      @(posedge clk);
      if (hold_rdy) begin
        resp_rdy <= 1'b1;
      end else begin
        resp_rdy <= ($urandom % 3) != 0;
      end
    end
  end

  // every test plus the timed one
  initial begin
    wait (tests_loaded);
    repeat ((test_req.size() + 1) * 40 + 200) @(posedge clk);
    fail_run("timeout, responses stopped arriving");
  end

  // --------------------
  // response side
  // --------------------

  always @(posedge clk) begin
    div_result_t exp_res;
    if (!reset) begin
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          fail_run("a response arrived with no request outstanding");
        end
        exp_res = exp_q.pop_front();
        check_result(resp, exp_res);
        rx_count++;
      end
      // a stall needs one divide waiting in prep and one in the core
      if (!req_rdy && exp_q.size() < 2) begin
        fail_run("req_rdy fell while the pipeline still had room");
      end
      if (i_int_div_unit.i_chk.fail_count != 0) begin
        fail_run("an assertion in the bound checker failed");
      end
    end
  end

  // --------------------
  // main sequence
  // --------------------

  initial begin
    reset        = 1'b1;
    req          = '0;
    req_val      = 1'b0;
    resp_rdy     = 1'b0;
    rx_count     = 0;
    hold_rdy     = 1'b0;
    tests_loaded = 1'b0;
    load_tests();
    tests_loaded = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    // back to back under random back-pressure
    foreach (test_req[i]) begin
      send_request(i);
    end
    req_val <= 1'b0;
    wait (rx_count == test_req.size());
    // lone request with resp_rdy held high
    hold_rdy = 1'b1;
    repeat (2) @(posedge clk);
    check_latency(0);
    wait (rx_count == test_req.size() + 1);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
src/int_div_pkg.sv
src/int_div_operand_prep.sv
src/int_div_iterative.sv
src/int_div_result_fix.sv
src/int_div_unit.sv
verification/int_div_unit_chk.sv
verification/int_div_unit_tb.sv

// File: Bender.yml
package:
  name: int_div_unit

sources:
  - include_dirs:
      - src
    files:
      - src/int_div_pkg.sv
      - src/int_div_operand_prep.sv
      - src/int_div_iterative.sv
      - src/int_div_result_fix.sv
      - src/int_div_unit.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/int_div_unit_chk.sv
      - verification/int_div_unit_tb.sv

// File: verification/int_div_tests.txt
# fn a b rem quo, one test per line, all hex
# fn 0 is signed, fn 1 is unsigned
1 00000064 00000007 00000002 0000000e
1 00000005 00000009 00000005 00000000
1 deadbeef 00000001 00000000 deadbeef
1 ffffffff 00000010 0000000f 0fffffff
1 80000000 00000003 00000002 2aaaaaaa
1 ffffffff ffffffff 00000000 00000001
1 12345678 00010000 00005678 00001234
1 fffffffe ffffffff fffffffe 00000000
0 00000064 00000007 00000002 0000000e
0 ffffff9c 00000007 fffffffe fffffff2
0 00000064 fffffff9 00000002 fffffff2
0 ffffff9c fffffff9 fffffffe 0000000e
0 80000000 ffffffff 00000000 80000000
0 ffffffff 00000002 ffffffff 00000000
0 fffffff9 00000002 ffffffff fffffffd
0 80000000 00000002 00000000 c0000000
1 12345678 00000000 12345678 ffffffff
0 00000005 00000000 00000005 ffffffff
0 fffffffb 00000000 fffffffb 00000001
0 80000000 00000000 80000000 00000001
